// File: hw/aluPkg.sv
package aluPkg;

    // datapath widths
    localparam int dataWidth   = 8;
    localparam int nibbleWidth = dataWidth / 2;

    // register stages between a request and its response
    localparam int pipeDepth   = 3;

    // packed BCD correction constants
    localparam logic [dataWidth-1:0] bcdLowAdj  = 8'h06;
    localparam logic [dataWidth-1:0] bcdHighAdj = 8'h60;
    localparam logic [dataWidth-1:0] bcdMax     = 8'h99;

    typedef enum logic [2:0] {
        opAdc,
        opSbc,
        opAnd,
        opEor,
        opOra,
        opRor
    } aluOpE;

    // one request per inValid strobe, each brings its own carry
    typedef struct packed {
        aluOpE                op;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic                 carryIn;
        logic                 decimalMode;
    } aluReqT;

    // one-hot operation selects, decimal selects already qualified
    typedef struct packed {
        logic sumSel;
        logic andSel;
        logic eorSel;
        logic orSel;
        logic shiftSel;
        logic decAdd;
        logic decSub;
    } aluCtrlT;

    // first stage output, opB is inverted for SBC
    typedef struct packed {
        aluCtrlT              ctrl;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic                 carryIn;
    } opStageT;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } aluFlagsT;

    // second stage output, binary result before decimal adjust
    typedef struct packed {
        logic [dataWidth-1:0] binResult;
        logic                 halfCarry;
        logic                 carryOut;
        logic                 overflow;
        logic                 decAdd;
        logic                 decSub;
    } binStageT;

    typedef struct packed {
        logic [dataWidth-1:0] result;
        aluFlagsT             flags;
    } aluRespT;

endpackage

// File: hw/operandStage.sv
`timescale 1ns/1ns

module operandStage (
    input  logic            rstAll,
    input  logic            arstN,
    input  logic            inValid,
    input  aluPkg::aluReqT  inReq,
    output logic            stage1Valid,
    output aluPkg::opStageT stage1
);

    import aluPkg::*;

    aluCtrlT ctrlNext;
    opStageT stageNext;

    // opcode to one-hot selects
    // decimal selects are resolved here so later stages never look at op again
    always_comb begin
        ctrlNext = '0;
        case (inReq.op)
            opAdc: begin
                ctrlNext.sumSel = 1'b1;
                ctrlNext.decAdd = inReq.decimalMode;
            end
            opSbc: begin
                ctrlNext.sumSel = 1'b1;
                ctrlNext.decSub = inReq.decimalMode;
            end
            opAnd: begin
                ctrlNext.andSel = 1'b1;
            end
            opEor: begin
                ctrlNext.eorSel = 1'b1;
            end
            opOra: begin
                ctrlNext.orSel = 1'b1;
            end
            opRor: begin
                ctrlNext.shiftSel = 1'b1;
            end
            default: begin
                ctrlNext = '0;
            end
        endcase
    end

    // subtract is an add of the inverted operand, carry acts as not-borrow
    always_comb begin
        stageNext.ctrl    = ctrlNext;
        stageNext.opA     = inReq.operandA;
        stageNext.opB     = (inReq.op == opSbc) ? ~inReq.operandB : inReq.operandB;
        stageNext.carryIn = inReq.carryIn;
    end

    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            stage1Valid <= 1'b0;
            stage1      <= '0;
        end else begin
            stage1Valid <= inValid;
            // payload only moves with a valid item
            if (inValid) begin
                stage1 <= stageNext;
            end
        end
    end

endmodule

// File: hw/aluStage.sv
`timescale 1ns/1ns

module aluStage (
    input  logic             rstAll,
    input  logic             arstN,
    input  logic             stage1Valid,
    input  aluPkg::opStageT  stage1,
    output logic             stage2Valid,
    output aluPkg::binStageT stage2
);

    import aluPkg::*;

    logic [nibbleWidth:0] lowSum;
    logic [nibbleWidth:0] highSum;
    logic [dataWidth-1:0] sumResult;
    logic                 sumOverflow;
    binStageT             stageNext;

    // add in two nibble steps so the half carry is visible
    always_comb begin
        lowSum  = {1'b0, stage1.opA[nibbleWidth-1:0]}
                + {1'b0, stage1.opB[nibbleWidth-1:0]}
                + {{nibbleWidth{1'b0}}, stage1.carryIn};
        highSum = {1'b0, stage1.opA[dataWidth-1:nibbleWidth]}
                + {1'b0, stage1.opB[dataWidth-1:nibbleWidth]}
                + {{nibbleWidth{1'b0}}, lowSum[nibbleWidth]};
    end

    assign sumResult = {highSum[nibbleWidth-1:0], lowSum[nibbleWidth-1:0]};

    // same sign in, different sign out
    assign sumOverflow = (stage1.opA[dataWidth-1] == stage1.opB[dataWidth-1])
                       && (stage1.opA[dataWidth-1] != sumResult[dataWidth-1]);

    always_comb begin
        // logic ops keep the incoming carry and clear overflow
        stageNext.binResult = '0;
        stageNext.halfCarry = 1'b0;
        stageNext.carryOut  = stage1.carryIn;
        stageNext.overflow  = 1'b0;
        stageNext.decAdd    = stage1.ctrl.decAdd;
        stageNext.decSub    = stage1.ctrl.decSub;

        if (stage1.ctrl.sumSel) begin
            stageNext.binResult = sumResult;
            stageNext.halfCarry = lowSum[nibbleWidth];
            stageNext.carryOut  = highSum[nibbleWidth];
            stageNext.overflow  = sumOverflow;
        end else if (stage1.ctrl.andSel) begin
            stageNext.binResult = stage1.opA & stage1.opB;
        end else if (stage1.ctrl.eorSel) begin
            stageNext.binResult = stage1.opA ^ stage1.opB;
        end else if (stage1.ctrl.orSel) begin
            stageNext.binResult = stage1.opA | stage1.opB;
        end else if (stage1.ctrl.shiftSel) begin
            // rotate right through carry on operand B
            stageNext.binResult = {stage1.carryIn, stage1.opB[dataWidth-1:1]};
            stageNext.carryOut  = stage1.opB[0];
        end
    end

    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            stage2Valid <= 1'b0;
            stage2      <= '0;
        end else begin
            stage2Valid <= stage1Valid;
            if (stage1Valid) begin
                stage2 <= stageNext;
            end
        end
    end

endmodule

// File: hw/decimalStage.sv
`timescale 1ns/1ns

module decimalStage (
    input  logic             rstAll,
    input  logic             arstN,
    input  logic             stage2Valid,
    input  aluPkg::binStageT stage2,
    output logic             outValid,
    output aluPkg::aluRespT  outResp
);

    import aluPkg::*;

    logic                 lowFix;
    logic                 highFix;
    logic [dataWidth-1:0] adjResult;
    logic                 adjCarry;
    aluRespT              respNext;

    // correction conditions, both taken from the binary result
    always_comb begin
        lowFix  = 1'b0;
        highFix = 1'b0;
        if (stage2.decAdd) begin
            // low digit past 9 or a carry out of it
            lowFix  = (stage2.binResult[nibbleWidth-1:0] > bcdMax[nibbleWidth-1:0])
                    || stage2.halfCarry;
            highFix = stage2.carryOut || (stage2.binResult > bcdMax);
        end else if (stage2.decSub) begin
            // a borrow out of a digit means it wrapped
            lowFix  = !stage2.halfCarry;
            highFix = !stage2.carryOut;
        end
    end

    always_comb begin
        adjResult = stage2.binResult;
        adjCarry  = stage2.carryOut;
        if (stage2.decAdd) begin
            if (lowFix) begin
                adjResult = adjResult + bcdLowAdj;
            end
            if (highFix) begin
                adjResult = adjResult + bcdHighAdj;
                // decimal carry, even when the binary add did not carry
                adjCarry  = 1'b1;
            end
        end else if (stage2.decSub) begin
            if (lowFix) begin
                adjResult = adjResult - bcdLowAdj;
            end
            if (highFix) begin
                adjResult = adjResult - bcdHighAdj;
            end
        end
    end

    // N and Z from the final result, V stays the binary overflow
    always_comb begin
        respNext.result  = adjResult;
        respNext.flags.n = adjResult[dataWidth-1];
        respNext.flags.v = stage2.overflow;
        respNext.flags.z = (adjResult == '0);
        respNext.flags.c = adjCarry;
    end

    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outResp  <= '0;
        end else begin
            outValid <= stage2Valid;
            if (stage2Valid) begin
                outResp <= respNext;
            end
        end
    end

endmodule

// File: hw/aluPipeTop.sv
`timescale 1ns/1ns

module aluPipeTop (
    input  logic            rstAll,
    input  logic            arstN,
    input  logic            inValid,
    input  aluPkg::aluReqT  inReq,
    output logic            outValid,
    output aluPkg::aluRespT outResp
);

    import aluPkg::*;

    // decode to ALU
    logic     stage1Valid;
    opStageT  stage1;

    // ALU to decimal adjust
    logic     stage2Valid;
    binStageT stage2;

    operandStage opStageInst (
        .rstAll      (rstAll),
        .arstN       (arstN),
        .inValid     (inValid),
        .inReq       (inReq),
        .stage1Valid (stage1Valid),
        .stage1      (stage1)
    );

    aluStage aluStageInst (
        .rstAll      (rstAll),
        .arstN       (arstN),
        .stage1Valid (stage1Valid),
        .stage1      (stage1),
        .stage2Valid (stage2Valid),
        .stage2      (stage2)
    );

    decimalStage decStageInst (
        .rstAll      (rstAll),
        .arstN       (arstN),
        .stage2Valid (stage2Valid),
        .stage2      (stage2),
        .outValid    (outValid),
        .outResp     (outResp)
    );

endmodule

// File: verif/aluPipeChecker.sv
`timescale 1ns/1ns

module aluPipeChecker (
    input  logic            rstAll,
    input  logic            arstN,
    input  logic            inValid,
    input  aluPkg::aluReqT  inReq,
    input  logic            outValid,
    input  aluPkg::aluRespT outResp,
    input  logic            endOfRun,
    output int              errCount,
    output int              checkCount,
    output int              pendingCount
);

    import aluPkg::*;

    aluRespT expQ[$];
    longint  stampQ[$];
    longint  cycleCount;
    bit      endReported;

    initial begin
        errCount     = 0;
        checkCount   = 0;
        pendingCount = 0;
        cycleCount   = 0;
        endReported  = 1'b0;
    end

    // reference model of the 6502 arithmetic rules
    function automatic aluRespT modelResp(input aluReqT req);
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] res;
        logic [8:0] sum;
        logic [4:0] low;
        logic       half;
        logic       carry;
        logic       ovf;
        logic       lowFix;
        logic       highFix;
        aluRespT    resp;
        a     = req.operandA;
        b     = (req.op == opSbc) ? ~req.operandB : req.operandB;
        res   = '0;
        half  = 1'b0;
        carry = req.carryIn;
        ovf   = 1'b0;
        case (req.op)
            opAdc, opSbc: begin
                sum   = {1'b0, a} + {1'b0, b} + req.carryIn;
                low   = {1'b0, a[3:0]} + {1'b0, b[3:0]} + req.carryIn;
                res   = sum[7:0];
                half  = low[4];
                carry = sum[8];
                ovf   = (a[7] == b[7]) && (res[7] != a[7]);
                if (req.decimalMode && req.op == opAdc) begin
                    lowFix  = (res[3:0] > 4'd9) || half;
                    highFix = carry || (res > bcdMax);
                    if (lowFix) res = res + bcdLowAdj;
                    if (highFix) begin
                        res   = res + bcdHighAdj;
                        carry = 1'b1;
                    end
                end else if (req.decimalMode) begin
                    // borrow out of a digit is a clear carry
                    if (!half) res = res - bcdLowAdj;
                    if (!carry) res = res - bcdHighAdj;
                end
            end
            opAnd: res = a & b;
            opEor: res = a ^ b;
            opOra: res = a | b;
            opRor: begin
                res   = {req.carryIn, req.operandB[7:1]};
                carry = req.operandB[0];
            end
            default: res = '0;
        endcase
        resp.result  = res;
        resp.flags.n = res[7];
        resp.flags.v = ovf;
        resp.flags.z = (res == 8'h00);
        resp.flags.c = carry;
        return resp;
    endfunction

    task automatic compareField(input string name, input logic [7:0] expV,
                                input logic [7:0] gotV);
        if (expV !== gotV) begin
            $display("mismatch %s: expected 0x%02h, actual 0x%02h", name, expV, gotV);
            errCount++;
        end
    endtask

    always @(posedge rstAll) begin : watchBlock
        aluRespT expResp;
        longint  stamp;
        cycleCount++;
        if (!arstN) begin
            if (outValid !== 1'b0) begin
                $display("outValid is not low while reset is asserted");
                errCount++;
            end
        end else begin
            if (outValid) begin
                if (expQ.size() == 0) begin
                    $display("unexpected response: outValid high with no request outstanding");
                    errCount++;
                end else begin
                    expResp = expQ.pop_front();
                    stamp   = stampQ.pop_front();
                    checkCount++;
                    compareField("result", expResp.result, outResp.result);
                    compareField("flag n", expResp.flags.n, outResp.flags.n);
                    compareField("flag v", expResp.flags.v, outResp.flags.v);
                    compareField("flag z", expResp.flags.z, outResp.flags.z);
                    compareField("flag c", expResp.flags.c, outResp.flags.c);
                    if (cycleCount - stamp != pipeDepth) begin
                        $display("latency error: response came %0d cycles after its request, not %0d",
                                 cycleCount - stamp, pipeDepth);
                        errCount++;
                    end
                end
            end
            if (inValid) begin
                expQ.push_back(modelResp(inReq));
                stampQ.push_back(cycleCount);
            end
        end
        if (endOfRun && !endReported) begin
            endReported = 1'b1;
            if (expQ.size() != 0) begin
                $display("%0d requests never received a response", expQ.size());
                errCount++;
            end
        end
        pendingCount = expQ.size();
    end

endmodule

// File: verif/aluPipe_assertions.sv
`timescale 1ns/1ns

module aluPipeAssertions (
    input logic            rstAll,
    input logic            arstN,
    input logic            inValid,
    input logic            outValid,
    input aluPkg::aluRespT outResp
);

    import aluPkg::*;

    // nothing leaves the pipeline while it is held in reset
    resetQuiet: assert property (@(posedge rstAll) !arstN |-> !outValid)
        else $error("outValid high while arstN is low");

    // every request comes out exactly pipeDepth edges later, gaps included
    latencyMatch: assert property (@(posedge rstAll) disable iff (!arstN)
        outValid == $past(inValid, pipeDepth))
        else $error("outValid does not follow inValid by the pipeline depth");

    zeroFlag: assert property (@(posedge rstAll) disable iff (!arstN)
        outValid |-> (outResp.flags.z == (outResp.result == '0)))
        else $error("flag z disagrees with the result");

    noUnknown: assert property (@(posedge rstAll) disable iff (!arstN)
        outValid |-> !$isunknown(outResp))
        else $error("outResp has unknown bits while outValid is high");

endmodule

bind aluPipeTop aluPipeAssertions assertInst (
    .rstAll   (rstAll),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .outResp  (outResp)
);

// File: verif/aluPipeTb.sv
`timescale 1ns/1ns

module aluPipeTb;

    import aluPkg::*;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 8;
    localparam int numTests     = 6;
    localparam int itemsPerTest = 64;
    localparam int maxGap       = 3;
    // cycles after the last request before missing responses count as lost
    localparam int drainLimit   = pipeDepth + 4;
    // room for the longest gap after every item plus drain and slack
    localparam int runLimitNs   = numTests * itemsPerTest * (maxGap + 1) * clkPeriod
                                + resetCycles * clkPeriod + 2000;

    // request mixes
    localparam int kindLogic   = 0;
    localparam int kindBinary  = 1;
    localparam int kindRotate  = 2;
    localparam int kindDecimal = 3;
    localparam int kindMixed   = 4;

    logic    rstAll;
    logic    arstN;
    logic    inValid;
    aluReqT  inReq;
    logic    outValid;
    aluRespT outResp;
    logic    endOfRun;
    int      errCount;
    int      checkCount;
    int      pendingCount;
    int      seedValue;
    int      testCount;

    aluPipeTop uut (
        .rstAll   (rstAll),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReq    (inReq),
        .outValid (outValid),
        .outResp  (outResp)
    );

    aluPipeChecker checkInst (
        .rstAll       (rstAll),
        .arstN        (arstN),
        .inValid      (inValid),
        .inReq        (inReq),
        .outValid     (outValid),
        .outResp      (outResp),
        .endOfRun     (endOfRun),
        .errCount     (errCount),
        .checkCount   (checkCount),
        .pendingCount (pendingCount)
    );

    initial begin
        rstAll = 1'b0;
        forever #(clkPeriod / 2) rstAll = ~rstAll;
    end

    initial begin
        #(runLimitNs);
        $display("watchdog: simulation did not finish within %0d ns", runLimitNs);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [7:0] randByte();
        int rnd;
        rnd = $urandom;
        return rnd[7:0];
    endfunction

    function automatic logic randBit();
        int rnd;
        rnd = $urandom_range(0, 1);
        return rnd[0];
    endfunction

    // two random decimal digits packed into one byte
    function automatic logic [7:0] randBcd();
        int hiDigit;
        int loDigit;
        hiDigit = $urandom_range(0, 9);
        loDigit = $urandom_range(0, 9);
        return {hiDigit[3:0], loDigit[3:0]};
    endfunction

    function automatic aluReqT makeReq(input int kind);
        aluReqT req;
        int     pick;
        req.operandA    = randByte();
        req.operandB    = randByte();
        req.carryIn     = randBit();
        req.decimalMode = randBit();
        case (kind)
            kindLogic: begin
                pick   = $urandom_range(0, 2);
                req.op = (pick == 0) ? opAnd : (pick == 1) ? opEor : opOra;
            end
            kindBinary: begin
                req.op          = randBit() ? opSbc : opAdc;
                req.decimalMode = 1'b0;
            end
            kindRotate: req.op = opRor;
            kindDecimal: begin
                req.op          = randBit() ? opSbc : opAdc;
                req.decimalMode = 1'b1;
                req.operandA    = randBcd();
                req.operandB    = randBcd();
            end
            default: begin
                pick   = $urandom_range(0, 5);
                req.op = aluOpE'(pick);
                if (req.decimalMode && (req.op == opAdc || req.op == opSbc)) begin
                    req.operandA = randBcd();
                    req.operandB = randBcd();
                end
            end
        endcase
        return req;
    endfunction

    // drive a burst and give the pipeline a bounded number of cycles to drain
    task automatic sendItems(input int kind, input int count, input bit useGaps);
        int gap;
        int waited;
        for (int i = 0; i < count; i++) begin
            @(posedge rstAll);
            inValid <= 1'b1;
            inReq   <= makeReq(kind);
            gap = useGaps ? $urandom_range(0, maxGap) : 0;
            repeat (gap) begin
                @(posedge rstAll);
                inValid <= 1'b0;
            end
        end
        @(posedge rstAll);
        inValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge rstAll);
            waited++;
        end while (pendingCount != 0 && waited < drainLimit);
    endtask

    task automatic reportTest(input string name, input int errBase, input int checkBase);
        testCount++;
        $display("test %-12s %0d responses checked, %0d errors",
                 name, checkCount - checkBase, errCount - errBase);
    endtask

    task automatic runTest(input string name, input int kind, input int count,
                           input bit useGaps);
        int errBase;
        int checkBase;
        errBase   = errCount;
        checkBase = checkCount;
        sendItems(kind, count, useGaps);
        reportTest(name, errBase, checkBase);
    endtask

    initial begin
        inValid   = 1'b0;
        inReq     = '0;
        endOfRun  = 1'b0;
        arstN     = 1'b1;
        testCount = 0;
        seedValue = $urandom(96);
        // falling edge on arstN lands before the first clock edge
        #1 arstN = 1'b0;
        repeat (resetCycles) @(posedge rstAll);
        arstN <= 1'b1;
        // any response during this idle stretch is stray
        repeat (6) @(posedge rstAll);
        sendItems(kindMixed, 1, 1'b0);
        reportTest("reset", 0, 0);

        runTest("logicOps", kindLogic, itemsPerTest, 1'b0);
        runTest("binaryArith", kindBinary, itemsPerTest, 1'b0);
        runTest("rotate", kindRotate, itemsPerTest, 1'b0);
        runTest("decimal", kindDecimal, itemsPerTest, 1'b0);
        runTest("streaming", kindMixed, itemsPerTest, 1'b1);

        @(posedge rstAll);
        endOfRun <= 1'b1;
        repeat (2) @(negedge rstAll);
        $display("summary: %0d tests, %0d responses checked, %0d errors",
                 testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/aluPkg.sv
hw/operandStage.sv
hw/aluStage.sv
hw/decimalStage.sv
hw/aluPipeTop.sv
verif/aluPipeChecker.sv
verif/aluPipe_assertions.sv
verif/aluPipeTb.sv
